/* dv/mips_exec_model.svh */
`ifndef MIPS_EXEC_MODEL_SVH
`define MIPS_EXEC_MODEL_SVH

// architectural state as the host should see it
word_t    model_regs [32];
word_t    model_hi;
word_t    model_lo;
word_t    model_sys_v0;
word_t    model_sys_a0;
word_t    model_sys_count;
word_t    model_pc;
// register the last instruction aimed at, zero if none
reg_idx_t model_dest;

// everything clears except sp, which starts one word under the stack top
function automatic void reset_model();
	for (int i = 0; i < 32; i++) begin
		model_regs[i] = '0;
	end
	model_regs[REG_SP] = STACK_TOP - 32'd4;
	model_hi = '0;
	model_lo = '0;
	model_sys_v0 = '0;
	model_sys_a0 = '0;
	model_sys_count = '0;
	model_pc = '0;
	model_dest = REG_ZERO;
endfunction

// executes one instruction word against the model state
function automatic void apply_model(input word_t ins);
	logic [5:0]  op;
	logic [5:0]  fn;
	word_t       a;
	word_t       b;
	word_t       res;
	logic [63:0] prod;
	reg_idx_t    dest;
	op = ins[31:26];
	fn = ins[5:0];
	a = model_regs[ins[25:21]];
	b = model_regs[ins[20:16]];
	res = '0;
	dest = REG_ZERO;
	case (op)
		OP_RTYPE: begin
			// rd is the target unless the funct only touches hi/lo or nothing
			dest = ins[15:11];
			case (fn)
				FN_ADDU: res = a + b;
				FN_SUBU: res = a - b;
				FN_AND: res = a & b;
				FN_OR: res = a | b;
				FN_XOR: res = a ^ b;
				FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				// shifts move rt by the shamt field
				FN_SLL: res = b << ins[10:6];
				FN_SRL: res = b >> ins[10:6];
				FN_MFHI: res = model_hi;
				FN_MFLO: res = model_lo;
				FN_MULT: begin
					prod = {32'h0, a} * {32'h0, b};
					model_hi = prod[63:32];
					model_lo = prod[31:0];
					dest = REG_ZERO;
				end
				FN_MTHI: begin
					model_hi = a;
					dest = REG_ZERO;
				end
				FN_MTLO: begin
					model_lo = a;
					dest = REG_ZERO;
				end
				FN_SYSCALL: begin
					model_sys_v0 = model_regs[REG_V0];
					model_sys_a0 = model_regs[REG_A0];
					model_sys_count = model_sys_count + 32'd1;
					dest = REG_ZERO;
				end
				default: dest = REG_ZERO;
			endcase
		end
		// link address is the pc most recently written by the host, plus 4
		OP_JAL: begin
			dest = REG_RA;
			res = model_pc + 32'd4;
		end
		OP_ADDIU: begin
			dest = ins[20:16];
			res = a + {{16{ins[15]}}, ins[15:0]};
		end
		OP_ORI: begin
			dest = ins[20:16];
			res = a | {16'h0000, ins[15:0]};
		end
		OP_LUI: begin
			dest = ins[20:16];
			res = {ins[15:0], 16'h0000};
		end
		default: dest = REG_ZERO;
	endcase
	// r0 never changes
	if (dest != REG_ZERO) begin
		model_regs[dest] = res;
	end
	model_dest = dest;
endfunction

`endif

/* dv/mips_exec_tb.sv */
`timescale 1ns/1ns

module mips_exec_tb;
	import mips_pkg::*;

	localparam word_t STACK_TOP = 32'h0000_1000;
	localparam int NUM_INSTR = 300;
	// about twenty cycles per instruction with its read-backs, plus reset and directed parts
	localparam int CYCLE_LIMIT = NUM_INSTR * 20 + 2000;
	// R-type functs for the random program, syscall is placed separately
	localparam logic [5:0] R_FUNCTS [13] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
		FN_SLT, FN_SLL, FN_SRL, FN_MULT, FN_MFHI, FN_MFLO, FN_MTHI, FN_MTLO};

	logic       clk;
	logic       rst;
	logic       s_awvalid;
	logic       s_awready;
	axil_addr_t s_awaddr;
	logic       s_wvalid;
	logic       s_wready;
	word_t      s_wdata;
	logic       s_bvalid;
	logic       s_bready;
	logic [1:0] s_bresp;
	logic       s_arvalid;
	logic       s_arready;
	axil_addr_t s_araddr;
	logic       s_rvalid;
	logic       s_rready;
	word_t      s_rdata;
	logic [1:0] s_rresp;

	int cycles = 0;
	int value_errors = 0;
	int other_errors = 0;

	`include "mips_exec_model.svh"

	mips_exec_top #(
		.STACK_TOP(STACK_TOP)
	) dut_i (
		.clk(clk), .rst(rst),
		.s_awvalid(s_awvalid), .s_awready(s_awready), .s_awaddr(s_awaddr),
		.s_wvalid(s_wvalid), .s_wready(s_wready), .s_wdata(s_wdata),
		.s_bvalid(s_bvalid), .s_bready(s_bready), .s_bresp(s_bresp),
		.s_arvalid(s_arvalid), .s_arready(s_arready), .s_araddr(s_araddr),
		.s_rvalid(s_rvalid), .s_rready(s_rready), .s_rdata(s_rdata), .s_rresp(s_rresp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// hard stop in case a handshake never completes
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	// aw and w together; lat counts cycles from the accepting edge to bvalid
	task automatic write_word(input axil_addr_t addr, input word_t data,
			input logic [1:0] exp_resp, output int lat);
		@(negedge clk);
		s_awvalid = 1'b1;
		s_awaddr = addr;
		s_wvalid = 1'b1;
		s_wdata = data;
		s_bready = 1'b1;
		while (!(s_awready && s_wready)) @(negedge clk);
		@(posedge clk);
		lat = 0;
		@(negedge clk);
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		while (!s_bvalid) begin
			lat++;
			@(negedge clk);
		end
		if (s_bresp !== exp_resp) begin
			$display("write to address %h answered with resp %b instead of %b",
				addr, s_bresp, exp_resp);
			other_errors++;
		end
		@(posedge clk);
		@(negedge clk);
		s_bready = 1'b0;
	endtask

	task automatic read_word(input axil_addr_t addr, input logic [1:0] exp_resp,
			output word_t data);
		@(negedge clk);
		s_arvalid = 1'b1;
		s_araddr = addr;
		s_rready = 1'b1;
		while (!s_arready) @(negedge clk);
		@(posedge clk);
		@(negedge clk);
		s_arvalid = 1'b0;
		while (!s_rvalid) @(negedge clk);
		data = s_rdata;
		if (s_rresp !== exp_resp) begin
			$display("read from address %h answered with resp %b instead of %b",
				addr, s_rresp, exp_resp);
			other_errors++;
		end
		@(posedge clk);
		@(negedge clk);
		s_rready = 1'b0;
	endtask

	task automatic expect_read(input string name, input axil_addr_t addr, input word_t expected);
		word_t data;
		read_word(addr, AXI_RESP_OKAY, data);
		check_value(name, expected, data);
	endtask

	// register r sits at 0x80 + 4*r
	task automatic expect_reg(input reg_idx_t idx);
		expect_read($sformatf("r%0d", idx), ADDR_REG_BASE | {1'b0, idx, 2'b00}, model_regs[idx]);
	endtask

	task automatic load_pc(input word_t pc_val);
		int lat;
		write_word(ADDR_PC, pc_val, AXI_RESP_OKAY, lat);
		// pc write answers on the accepting edge
		check_value("pc bvalid latency", 32'd0, 32'(lat));
		model_pc = pc_val;
	endtask

	// one instruction, then read back whatever it should have changed
	task automatic issue_instr(input word_t ins);
		int lat;
		logic [5:0] op;
		logic [5:0] fn;
		op = ins[31:26];
		fn = ins[5:0];
		write_word(ADDR_INSTR, ins, AXI_RESP_OKAY, lat);
		// decode, operand read, execute before the response
		check_value("instr bvalid latency", 32'd3, 32'(lat));
		apply_model(ins);
		expect_reg(model_dest);
		if (op == OP_RTYPE && (fn == FN_MULT || fn == FN_MTHI || fn == FN_MTLO)) begin
			expect_read("hi", ADDR_HI, model_hi);
			expect_read("lo", ADDR_LO, model_lo);
		end
		if (op == OP_RTYPE && fn == FN_SYSCALL) begin
			expect_read("sys_v0", ADDR_SYS_V0, model_sys_v0);
			expect_read("sys_a0", ADDR_SYS_A0, model_sys_a0);
			expect_read("sys_count", ADDR_SYS_COUNT, model_sys_count);
		end
	endtask

	function automatic word_t r_format(input reg_idx_t rs, input reg_idx_t rt, input reg_idx_t rd,
			input logic [4:0] sh, input logic [5:0] fn);
		return {OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t i_format(input logic [5:0] op, input reg_idx_t rs,
			input reg_idx_t rt, input logic [15:0] imm16);
		return {op, rs, rt, imm16};
	endfunction

	// every 25th a syscall, every 10th a jal, otherwise a random pick of the subset
	function automatic word_t make_instr(input int k);
		reg_idx_t    rs_r;
		reg_idx_t    rt_r;
		reg_idx_t    rd_r;
		logic [4:0]  sh;
		logic [15:0] imm16;
		int          pick;
		rs_r = 5'($urandom);
		rt_r = 5'($urandom);
		rd_r = 5'($urandom);
		sh = 5'($urandom);
		imm16 = 16'($urandom);
		pick = int'($urandom % 16);
		if (k % 25 == 24) begin
			return r_format(5'd0, 5'd0, 5'd0, 5'd0, FN_SYSCALL);
		end
		if (k % 10 == 9) begin
			return {OP_JAL, 26'($urandom)};
		end
		if (pick < 13) begin
			return r_format(rs_r, rt_r, rd_r, sh, R_FUNCTS[pick]);
		end
		return i_format((pick == 13) ? OP_ADDIU : (pick == 14) ? OP_ORI : OP_LUI,
			rs_r, rt_r, imm16);
	endfunction

	initial begin
		word_t data;
		word_t ins;
		int    lat;
		rst = 1'b1;
		s_awvalid = 1'b0;
		s_awaddr = '0;
		s_wvalid = 1'b0;
		s_wdata = '0;
		s_bready = 1'b0;
		s_arvalid = 1'b0;
		s_araddr = '0;
		s_rready = 1'b0;
		void'($urandom(32'h90960459));
		reset_model();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// reset values of every register and of hi, lo and the syscall count
		for (int r = 0; r < 32; r++) begin
			expect_reg(5'(r));
		end
		expect_read("hi", ADDR_HI, model_hi);
		expect_read("lo", ADDR_LO, model_lo);
		expect_read("sys_count", ADDR_SYS_COUNT, model_sys_count);

		// unmapped write and reads, the last one misaligned inside the register window
		write_word(8'h1c, 32'hdead_beef, AXI_RESP_SLVERR, lat);
		read_word(8'h1c, AXI_RESP_SLVERR, data);
		check_value("unmapped read data", 32'h0, data);
		read_word(8'h82, AXI_RESP_SLVERR, data);
		check_value("misaligned read data", 32'h0, data);

		for (int k = 0; k < NUM_INSTR; k++) begin
			ins = make_instr(k);
			// jal and syscall each get a fresh word-aligned pc first
			if (ins[31:26] == OP_JAL || (ins[31:26] == OP_RTYPE && ins[5:0] == FN_SYSCALL)) begin
				load_pc(word_t'($urandom) & 32'hffff_fffc);
			end
			issue_instr(ins);
		end

		// hi/lo round trip on registers the random program has filled
		issue_instr(r_format(5'd8, 5'd9, 5'd0, 5'd0, FN_MULT));
		issue_instr(r_format(5'd0, 5'd0, 5'd10, 5'd0, FN_MFHI));
		issue_instr(r_format(5'd0, 5'd0, 5'd11, 5'd0, FN_MFLO));
		issue_instr(r_format(5'd12, 5'd0, 5'd0, 5'd0, FN_MTHI));
		issue_instr(r_format(5'd13, 5'd0, 5'd0, 5'd0, FN_MTLO));

		$display("summary: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* mips_exec_top.f */
+incdir+dv
verilog/mips_pkg.sv
verilog/axil_instr_port.sv
verilog/instr_decoder.sv
verilog/register_file.sv
verilog/alu_hilo.sv
verilog/syscall_capture.sv
verilog/mips_exec_top.sv
dv/mips_exec_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and decide on the pass line in the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mips_exec_top.f --top-module mips_exec_tb \
	-o mips_exec_sim > build.log 2>&1 \
	&& ./obj_dir/mips_exec_sim > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* verilog/alu_hilo.sv */
`timescale 1ns/1ns

module alu_hilo (
	input  logic               clk,
	input  logic               rst,
	input  logic               op_valid,
	input  mips_pkg::alu_op_t  alu_op,
	input  mips_pkg::reg_idx_t rd_dest,
	input  mips_pkg::word_t    imm,
	input  logic [4:0]         shamt,
	input  logic               use_imm,
	input  mips_pkg::word_t    read_data_1,
	input  mips_pkg::word_t    read_data_2,
	output logic               wb_en,
	output mips_pkg::reg_idx_t wb_idx,
	output mips_pkg::word_t    wb_data,
	output mips_pkg::word_t    hi,
	output mips_pkg::word_t    lo,
	output logic               retire,
	output logic               sys_event
);
	import mips_pkg::*;

	word_t       opnd_b;
	word_t       result;
	logic [63:0] product;

	// second operand is the immediate for I-type
	assign opnd_b = use_imm ? imm : read_data_2;

	// mult is unsigned, full 64 bits
	assign product = {32'h0, read_data_1} * {32'h0, read_data_2};

	always_comb begin
		case (alu_op)
			ALU_ADDU: result = read_data_1 + opnd_b;
			ALU_SUBU: result = read_data_1 - opnd_b;
			ALU_AND: result = read_data_1 & opnd_b;
			ALU_OR: result = read_data_1 | opnd_b;
			ALU_XOR: result = read_data_1 ^ opnd_b;
			ALU_SLT: result = {31'h0, $signed(read_data_1) < $signed(opnd_b)};
			// shifts act on rt
			ALU_SLL: result = read_data_2 << shamt;
			ALU_SRL: result = read_data_2 >> shamt;
			ALU_LUI: result = {imm[15:0], 16'h0000};
			// mfhi, mflo and jal already have their value on operand 1
			ALU_PASS: result = read_data_1;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			hi <= '0;
			lo <= '0;
		end else if (op_valid) begin
			case (alu_op)
				ALU_MULT: begin
					hi <= product[63:32];
					lo <= product[31:0];
				end
				ALU_MTHI: hi <= read_data_1;
				ALU_MTLO: lo <= read_data_1;
				default: begin
					hi <= hi;
				end
			endcase
		end
	end

	// writeback lands on the same edge as hi/lo
	assign wb_en = op_valid && (rd_dest != REG_ZERO);
	assign wb_idx = rd_dest;
	assign wb_data = result;

	// one instruction in flight, so every valid operand set retires now
	assign retire = op_valid;
	assign sys_event = op_valid && (alu_op == ALU_SYSCALL);

endmodule

/* verilog/axil_instr_port.sv */
`timescale 1ns/1ns

module axil_instr_port (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 s_awvalid,
	output logic                 s_awready,
	input  mips_pkg::axil_addr_t s_awaddr,
	input  logic                 s_wvalid,
	output logic                 s_wready,
	input  mips_pkg::word_t      s_wdata,
	output logic                 s_bvalid,
	input  logic                 s_bready,
	output logic [1:0]           s_bresp,
	input  logic                 s_arvalid,
	output logic                 s_arready,
	input  mips_pkg::axil_addr_t s_araddr,
	output logic                 s_rvalid,
	input  logic                 s_rready,
	output mips_pkg::word_t      s_rdata,
	output logic [1:0]           s_rresp,
	input  logic                 retire,
	input  mips_pkg::word_t      dbg_data,
	input  mips_pkg::word_t      hi,
	input  mips_pkg::word_t      lo,
	input  mips_pkg::word_t      sys_v0,
	input  mips_pkg::word_t      sys_a0,
	input  mips_pkg::word_t      sys_count,
	output logic                 instr_valid,
	output mips_pkg::word_t      instr,
	output mips_pkg::word_t      pc,
	output mips_pkg::reg_idx_t   dbg_idx
);
	import mips_pkg::*;

	typedef enum logic [1:0] {WR_IDLE, WR_BUSY, WR_RESP} wr_state_t;
	typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

	wr_state_t wr_state;
	rd_state_t rd_state;
	logic      wr_rdy;
	logic      wr_fire;
	logic      rd_fire;
	logic      reg_hit;
	logic      rd_err;
	word_t     rd_mux;

	// aw and w are taken together, only while idle
	assign s_awready = wr_rdy;
	assign s_wready = wr_rdy;
	assign wr_fire = wr_rdy && s_awvalid && s_wvalid;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= WR_IDLE;
			wr_rdy <= 1'b0;
			s_bvalid <= 1'b0;
			s_bresp <= AXI_RESP_OKAY;
			instr_valid <= 1'b0;
			pc <= '0;
		end else begin
			// instr_valid is a single-cycle pulse
			instr_valid <= 1'b0;
			case (wr_state)
				WR_IDLE: begin
					wr_rdy <= 1'b1;
					if (wr_fire) begin
						wr_rdy <= 1'b0;
						s_bresp <= AXI_RESP_OKAY;
						if (s_awaddr == ADDR_INSTR) begin
							instr <= s_wdata;
							instr_valid <= 1'b1;
							wr_state <= WR_BUSY;
						end else if (s_awaddr == ADDR_PC) begin
							pc <= s_wdata;
							s_bvalid <= 1'b1;
							wr_state <= WR_RESP;
						end else begin
							// unmapped write, no side effect
							s_bresp <= AXI_RESP_SLVERR;
							s_bvalid <= 1'b1;
							wr_state <= WR_RESP;
						end
					end
				end
				WR_BUSY: begin
					// answer only once the instruction has retired
					if (retire) begin
						s_bvalid <= 1'b1;
						wr_state <= WR_RESP;
					end
				end
				default: begin
					if (s_bready) begin
						s_bvalid <= 1'b0;
						wr_rdy <= 1'b1;
						wr_state <= WR_IDLE;
					end
				end
			endcase
		end
	end

	// read side runs on its own
	assign s_arready = (rd_state == RD_IDLE);
	assign s_rvalid = (rd_state == RD_DATA);
	assign rd_fire = s_arvalid && s_arready;

	// register window, word aligned only
	assign reg_hit = (s_araddr >= ADDR_REG_BASE) && (s_araddr[1:0] == 2'b00);
	assign dbg_idx = s_araddr[6:2];

	always_comb begin
		rd_mux = '0;
		rd_err = 1'b0;
		case (s_araddr)
			ADDR_SYS_V0: rd_mux = sys_v0;
			ADDR_SYS_A0: rd_mux = sys_a0;
			ADDR_SYS_COUNT: rd_mux = sys_count;
			ADDR_HI: rd_mux = hi;
			ADDR_LO: rd_mux = lo;
			default: begin
				if (reg_hit) begin
					rd_mux = dbg_data;
				end else begin
					rd_err = 1'b1;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= RD_IDLE;
		end else if (rd_state == RD_IDLE) begin
			if (rd_fire) begin
				rd_state <= RD_DATA;
			end
		end else if (s_rready) begin
			rd_state <= RD_IDLE;
		end
	end

	// data captured at the address handshake, held until rready
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			s_rdata <= rd_mux;
			s_rresp <= rd_err ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
		end
	end

endmodule

/* verilog/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder (
	input  logic               clk,
	input  logic               rst,
	input  logic               instr_valid,
	input  mips_pkg::word_t    instr,
	input  mips_pkg::word_t    pc,
	output logic               dec_valid,
	output mips_pkg::reg_idx_t rs,
	output mips_pkg::reg_idx_t rt,
	output mips_pkg::reg_idx_t rd_dest,
	output mips_pkg::word_t    imm,
	output logic [4:0]         shamt,
	output logic               use_imm,
	output mips_pkg::alu_op_t  alu_op,
	output mips_pkg::opsel_t   opsel,
	output mips_pkg::word_t    pc_plus_4
);
	import mips_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_idx_t   f_rt;
	reg_idx_t   f_rd;
	logic [15:0] f_imm;
	alu_op_t    op_next;
	reg_idx_t   dest_next;
	opsel_t     opsel_next;
	logic       imm_next;
	word_t      imm_ext;

	// instruction fields
	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign f_rt = instr[20:16];
	assign f_rd = instr[15:11];
	assign f_imm = instr[15:0];

	// only addiu sign-extends, ori and lui take the raw halfword
	assign imm_ext = (opcode == OP_ADDIU) ? {{16{f_imm[15]}}, f_imm} : {16'h0000, f_imm};

	always_comb begin
		// unknown codes fall through as a no-op with no destination
		op_next = ALU_NOP;
		dest_next = REG_ZERO;
		opsel_next = OPSEL_REGS;
		imm_next = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				dest_next = f_rd;
				case (funct)
					FN_ADDU: op_next = ALU_ADDU;
					FN_SUBU: op_next = ALU_SUBU;
					FN_AND: op_next = ALU_AND;
					FN_OR: op_next = ALU_OR;
					FN_XOR: op_next = ALU_XOR;
					FN_SLT: op_next = ALU_SLT;
					FN_SLL: op_next = ALU_SLL;
					FN_SRL: op_next = ALU_SRL;
					FN_MFHI: begin
						op_next = ALU_PASS;
						opsel_next = OPSEL_HI;
					end
					FN_MFLO: begin
						op_next = ALU_PASS;
						opsel_next = OPSEL_LO;
					end
					// these touch hi/lo or nothing, never the register file
					FN_MULT: begin
						op_next = ALU_MULT;
						dest_next = REG_ZERO;
					end
					FN_MTHI: begin
						op_next = ALU_MTHI;
						dest_next = REG_ZERO;
					end
					FN_MTLO: begin
						op_next = ALU_MTLO;
						dest_next = REG_ZERO;
					end
					FN_SYSCALL: begin
						// operands become v0 and a0
						op_next = ALU_SYSCALL;
						dest_next = REG_ZERO;
						opsel_next = OPSEL_SYSCALL;
					end
					default: dest_next = REG_ZERO;
				endcase
			end
			OP_JAL: begin
				// link value comes in as operand 1
				op_next = ALU_PASS;
				dest_next = REG_RA;
				opsel_next = OPSEL_JAL;
			end
			OP_ADDIU: begin
				op_next = ALU_ADDU;
				dest_next = f_rt;
				imm_next = 1'b1;
			end
			OP_ORI: begin
				op_next = ALU_OR;
				dest_next = f_rt;
				imm_next = 1'b1;
			end
			OP_LUI: begin
				op_next = ALU_LUI;
				dest_next = f_rt;
				imm_next = 1'b1;
			end
			default: begin
				op_next = ALU_NOP;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= instr_valid;
		end
	end

	// controls stay put until the next instruction arrives
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			rs <= instr[25:21];
			rt <= f_rt;
			rd_dest <= dest_next;
			imm <= imm_ext;
			shamt <= instr[10:6];
			use_imm <= imm_next;
			alu_op <= op_next;
			opsel <= opsel_next;
			pc_plus_4 <= pc + 32'd4;
		end
	end

endmodule

/* verilog/mips_exec_top.sv */
`timescale 1ns/1ns

module mips_exec_top #(
	parameter mips_pkg::word_t STACK_TOP = 32'h0000_1000
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 s_awvalid,
	output logic                 s_awready,
	input  mips_pkg::axil_addr_t s_awaddr,
	input  logic                 s_wvalid,
	output logic                 s_wready,
	input  mips_pkg::word_t      s_wdata,
	output logic                 s_bvalid,
	input  logic                 s_bready,
	output logic [1:0]           s_bresp,
	input  logic                 s_arvalid,
	output logic                 s_arready,
	input  mips_pkg::axil_addr_t s_araddr,
	output logic                 s_rvalid,
	input  logic                 s_rready,
	output mips_pkg::word_t      s_rdata,
	output logic [1:0]           s_rresp
);
	import mips_pkg::*;

	// port to decoder
	logic     instr_valid;
	word_t    instr;
	word_t    pc;
	// decoder to register file and ALU
	logic     dec_valid;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd_dest;
	word_t    imm;
	logic [4:0] shamt;
	logic     use_imm;
	alu_op_t  alu_op;
	opsel_t   opsel;
	word_t    pc_plus_4;
	// operands and writeback
	logic     op_valid;
	word_t    read_data_1;
	word_t    read_data_2;
	logic     wb_en;
	reg_idx_t wb_idx;
	word_t    wb_data;
	// status and read-back sources
	word_t    hi;
	word_t    lo;
	logic     retire;
	logic     sys_event;
	word_t    sys_v0;
	word_t    sys_a0;
	word_t    sys_count;
	reg_idx_t dbg_idx;
	word_t    dbg_data;

	axil_instr_port port_i (
		.clk(clk), .rst(rst),
		.s_awvalid(s_awvalid), .s_awready(s_awready), .s_awaddr(s_awaddr),
		.s_wvalid(s_wvalid), .s_wready(s_wready), .s_wdata(s_wdata),
		.s_bvalid(s_bvalid), .s_bready(s_bready), .s_bresp(s_bresp),
		.s_arvalid(s_arvalid), .s_arready(s_arready), .s_araddr(s_araddr),
		.s_rvalid(s_rvalid), .s_rready(s_rready), .s_rdata(s_rdata), .s_rresp(s_rresp),
		.retire(retire), .dbg_data(dbg_data), .hi(hi), .lo(lo),
		.sys_v0(sys_v0), .sys_a0(sys_a0), .sys_count(sys_count),
		.instr_valid(instr_valid), .instr(instr), .pc(pc), .dbg_idx(dbg_idx)
	);

	instr_decoder decoder_i (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .pc(pc),
		.dec_valid(dec_valid), .rs(rs), .rt(rt), .rd_dest(rd_dest), .imm(imm),
		.shamt(shamt), .use_imm(use_imm), .alu_op(alu_op), .opsel(opsel),
		.pc_plus_4(pc_plus_4)
	);

	register_file #(
		.STACK_TOP(STACK_TOP)
	) regfile_i (
		.clk(clk), .rst(rst), .dec_valid(dec_valid), .rs(rs), .rt(rt), .opsel(opsel),
		.pc_plus_4(pc_plus_4), .hi(hi), .lo(lo),
		.wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data), .dbg_idx(dbg_idx),
		.op_valid(op_valid), .read_data_1(read_data_1), .read_data_2(read_data_2),
		.dbg_data(dbg_data)
	);

	alu_hilo alu_i (
		.clk(clk), .rst(rst), .op_valid(op_valid), .alu_op(alu_op), .rd_dest(rd_dest),
		.imm(imm), .shamt(shamt), .use_imm(use_imm),
		.read_data_1(read_data_1), .read_data_2(read_data_2),
		.wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data), .hi(hi), .lo(lo),
		.retire(retire), .sys_event(sys_event)
	);

	syscall_capture sys_i (
		.clk(clk), .rst(rst), .sys_event(sys_event),
		.read_data_1(read_data_1), .read_data_2(read_data_2),
		.sys_v0(sys_v0), .sys_a0(sys_a0), .sys_count(sys_count)
	);

endmodule

/* verilog/mips_pkg.sv */
package mips_pkg;

	// data word for registers, pc, results and bus data
	typedef logic [31:0] word_t;
	// architectural register index
	typedef logic [4:0] reg_idx_t;
	// byte address on the AXI4-Lite port
	typedef logic [7:0] axil_addr_t;

	// ALU operation carried from decode to execute
	// syscall rides as its own code so execute can flag the event
	typedef enum logic [3:0] {
		ALU_ADDU,
		ALU_SUBU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI,
		ALU_MULT,
		ALU_MTHI,
		ALU_MTLO,
		ALU_PASS,
		ALU_NOP,
		ALU_SYSCALL
	} alu_op_t;

	// operand override applied by the register file read
	typedef enum logic [2:0] {
		OPSEL_REGS,
		OPSEL_SYSCALL,
		OPSEL_JAL,
		OPSEL_HI,
		OPSEL_LO
	} opsel_t;

	// primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_JAL = 6'h03;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;

	// R-type funct codes
	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_SRL = 6'h02;
	localparam logic [5:0] FN_SYSCALL = 6'h0c;
	localparam logic [5:0] FN_MFHI = 6'h10;
	localparam logic [5:0] FN_MTHI = 6'h11;
	localparam logic [5:0] FN_MFLO = 6'h12;
	localparam logic [5:0] FN_MTLO = 6'h13;
	localparam logic [5:0] FN_MULT = 6'h18;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2a;

	// fixed register numbers
	localparam reg_idx_t REG_ZERO = 5'd0;
	localparam reg_idx_t REG_V0 = 5'd2;
	localparam reg_idx_t REG_A0 = 5'd4;
	localparam reg_idx_t REG_SP = 5'd29;
	localparam reg_idx_t REG_RA = 5'd31;

	// host address map
	localparam axil_addr_t ADDR_INSTR = 8'h00;
	localparam axil_addr_t ADDR_PC = 8'h04;
	localparam axil_addr_t ADDR_SYS_V0 = 8'h08;
	localparam axil_addr_t ADDR_SYS_A0 = 8'h0c;
	localparam axil_addr_t ADDR_SYS_COUNT = 8'h10;
	localparam axil_addr_t ADDR_HI = 8'h14;
	localparam axil_addr_t ADDR_LO = 8'h18;
	// register r sits at base + 4*r
	localparam axil_addr_t ADDR_REG_BASE = 8'h80;

	// AXI response codes
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

/* verilog/register_file.sv */
`timescale 1ns/1ns

module register_file #(
	parameter mips_pkg::word_t STACK_TOP = 32'h0000_1000
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               dec_valid,
	input  mips_pkg::reg_idx_t rs,
	input  mips_pkg::reg_idx_t rt,
	input  mips_pkg::opsel_t   opsel,
	input  mips_pkg::word_t    pc_plus_4,
	input  mips_pkg::word_t    hi,
	input  mips_pkg::word_t    lo,
	input  logic               wb_en,
	input  mips_pkg::reg_idx_t wb_idx,
	input  mips_pkg::word_t    wb_data,
	input  mips_pkg::reg_idx_t dbg_idx,
	output logic               op_valid,
	output mips_pkg::word_t    read_data_1,
	output mips_pkg::word_t    read_data_2,
	output mips_pkg::word_t    dbg_data
);
	import mips_pkg::*;

	// architectural registers
	word_t regs [32];

	// sp comes out of reset just below the stack top, the rest at zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= (i == int'(REG_SP)) ? (STACK_TOP - 32'd4) : '0;
			end
		end else if (wb_en && (wb_idx != REG_ZERO)) begin
			// r0 stays hardwired
			regs[wb_idx] <= wb_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			op_valid <= 1'b0;
		end else begin
			op_valid <= dec_valid;
		end
	end

	// operand fetch, override order syscall, jal, hi, lo, then rs/rt
	always_ff @(posedge clk) begin
		if (dec_valid) begin
			case (opsel)
				OPSEL_SYSCALL: begin
					read_data_1 <= regs[REG_V0];
					read_data_2 <= regs[REG_A0];
				end
				OPSEL_JAL: begin
					read_data_1 <= pc_plus_4;
					read_data_2 <= regs[REG_ZERO];
				end
				OPSEL_HI: begin
					read_data_1 <= hi;
					read_data_2 <= '0;
				end
				OPSEL_LO: begin
					read_data_1 <= lo;
					read_data_2 <= '0;
				end
				default: begin
					read_data_1 <= regs[rs];
					read_data_2 <= regs[rt];
				end
			endcase
		end
	end

	// host read-back path
	assign dbg_data = regs[dbg_idx];

endmodule

/* verilog/syscall_capture.sv */
`timescale 1ns/1ns

module syscall_capture (
	input  logic            clk,
	input  logic            rst,
	input  logic            sys_event,
	input  mips_pkg::word_t read_data_1,
	input  mips_pkg::word_t read_data_2,
	output mips_pkg::word_t sys_v0,
	output mips_pkg::word_t sys_a0,
	output mips_pkg::word_t sys_count
);

	// operands already hold v0 and a0 during a syscall
	always_ff @(posedge clk) begin
		if (rst) begin
			sys_v0 <= '0;
			sys_a0 <= '0;
			sys_count <= '0;
		end else if (sys_event) begin
			sys_v0 <= read_data_1;
			sys_a0 <= read_data_2;
			// running total of retired syscalls
			sys_count <= sys_count + 32'd1;
		end
	end

endmodule
